// ==== src/dma_pkg.sv ====
package dma_pkg;

    // ==============================
    // Bus and buffer widths
    // ==============================
    localparam int AXI_ADDR_W = 32;   // DRAM byte address
    localparam int AXI_DATA_W = 64;   // One AXI beat
    localparam int MEM_DATA_W = 32;   // One buffer word
    localparam int BEAT_BYTES = AXI_DATA_W / 8;
    localparam int BURST_MAX  = 16;   // Beats per INCR burst, upper bound

    // AR channel encodings
    localparam logic [2:0] AXI_SIZE_8B    = 3'd3;  // 2**3 bytes per beat
    localparam logic [1:0] AXI_BURST_INCR = 2'd1;

    typedef logic [AXI_ADDR_W-1:0] addr_t;       // DRAM byte address
    typedef logic [31:0]           len_t;        // Length in bytes
    typedef logic [31:0]           word_addr_t;  // Buffer word offset

    // On-chip destination buffers
    typedef enum logic [1:0] {
        BUF_ACT_A  = 2'd0,
        BUF_ACT_B  = 2'd1,
        BUF_WEIGHT = 2'd2,
        BUF_OUTPUT = 2'd3
    } buffer_id_t;

    // One beat seen as a bus word or as two buffer words
    typedef union packed {
        logic [AXI_DATA_W-1:0]            raw;
        logic [1:0][MEM_DATA_W-1:0]       word;  // Index 0 is the low word
    } axi_beat_u;

endpackage

// ==== src/dma_ctrl_if.sv ====
`timescale 1ns/1ps

interface dma_ctrl_if;
    import dma_pkg::*;

    // Sequencer to register block
    logic       load;         // Latch a new command
    logic       burst_done;   // Last beat of a burst accepted

    // Register block to sequencer and AR channel
    addr_t      cur_addr;     // Address of the next burst
    logic [7:0] cur_arlen;    // Beats of the next burst minus one
    logic       more_bursts;  // Bytes left after this burst

    modport fsm (
        output load,
        output burst_done,
        input  more_bursts
    );

    modport regs (
        input  load,
        input  burst_done,
        output cur_addr,
        output cur_arlen,
        output more_bursts
    );

endinterface

// ==== src/dma_xfer_regs.sv ====
`timescale 1ns/1ps

module dma_xfer_regs (
    input  logic                clk,
    input  logic                rst_n,
    dma_ctrl_if.regs            ctrl,
    input  dma_pkg::addr_t      src_addr,
    input  dma_pkg::len_t       length,
    input  dma_pkg::buffer_id_t target_buf,
    output dma_pkg::buffer_id_t mem_target
);
    import dma_pkg::*;

    len_t       remaining_q;  // Bytes not yet requested, current burst included
    logic [7:0] arlen_q;
    addr_t      addr_q;
    buffer_id_t target_q;
    len_t       burst_bytes;  // Size of the burst now on the bus
    len_t       rem_next;     // Remainder once this burst completes

    // Beat count minus one for the next burst, from the bytes left
    function automatic logic [7:0] calc_arlen(input len_t bytes);
        len_t beats;
        beats = bytes / len_t'(BEAT_BYTES);
        if (beats >= len_t'(BURST_MAX)) begin
            calc_arlen = 8'(BURST_MAX - 1);  // Full burst
        end else if (beats == '0) begin
            calc_arlen = '0;                 // Nothing left, value unused
        end else begin
            calc_arlen = 8'(beats - len_t'(1));
        end
    endfunction

    // ==============================
    // Burst bookkeeping
    // ==============================
    assign burst_bytes = (len_t'(arlen_q) + len_t'(1)) * len_t'(BEAT_BYTES);
    assign rem_next    = remaining_q - burst_bytes;

    // Control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remaining_q <= '0;
            arlen_q     <= '0;
        end else if (ctrl.load) begin
            remaining_q <= length;
            arlen_q     <= calc_arlen(length);  // First burst sized from the full length
        end else if (ctrl.burst_done) begin
            remaining_q <= rem_next;
            arlen_q     <= calc_arlen(rem_next);  // Recomputed, so a short tail burst works
        end
    end

    // Address and target are payload
    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            addr_q   <= src_addr;
            target_q <= target_buf;
        end else if (ctrl.burst_done) begin
            addr_q   <= addr_q + addr_t'(burst_bytes);  // Step past the finished burst
        end
    end

    // ==============================
    // Outputs
    // ==============================
    assign ctrl.cur_addr    = addr_q;
    assign ctrl.cur_arlen   = arlen_q;
    assign ctrl.more_bursts = (remaining_q > burst_bytes);
    assign mem_target       = target_q;

    // Whole beats only, and at least one
    a_len_legal : assert property (
        @(posedge clk) disable iff (!rst_n)
        ctrl.load |-> ((length != '0) && (length[2:0] == 3'b000))
    );

endmodule

// ==== src/dma_read_fsm.sv ====
`timescale 1ns/1ps

module dma_read_fsm (
    input  logic     clk,
    input  logic     rst_n,
    dma_ctrl_if.fsm  ctrl,
    input  logic     start,
    input  logic     arready,
    output logic     arvalid,
    input  logic     beat_last,   // Handshake on the rlast beat
    output logic     data_phase,
    output logic     busy,
    output logic     done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,   // AR held on the bus
        ST_DATA,   // Beats of one burst
        ST_DONE    // One-cycle completion
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   accept;  // Start taken this cycle

    // ==============================
    // Command acceptance
    // ==============================
    // Start counts only while not busy
    assign accept = start && ((state_q == ST_IDLE) || (state_q == ST_DONE));

    // ==============================
    // Next state
    // ==============================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (arready) begin
                    state_d = ST_DATA;  // Address taken
                end
            end
            ST_DATA: begin
                if (beat_last) begin
                    // Another burst or finish
                    state_d = ctrl.more_bursts ? ST_ADDR : ST_DONE;
                end
            end
            ST_DONE: begin
                state_d = accept ? ST_ADDR : ST_IDLE;  // Back-to-back command allowed
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ==============================
    // Outputs
    // ==============================
    assign arvalid         = (state_q == ST_ADDR);
    assign data_phase      = (state_q == ST_DATA);
    assign busy            = (state_q == ST_ADDR) || (state_q == ST_DATA);
    assign done            = (state_q == ST_DONE);
    assign ctrl.load       = accept;
    assign ctrl.burst_done = data_phase && beat_last;  // Registers advance next cycle

    // AR request is held until the slave takes it
    a_arvalid_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        (arvalid && !arready) |=> arvalid
    );

endmodule

// ==== src/beat_unpacker.sv ====
`timescale 1ns/1ps

module beat_unpacker (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             data_phase,
    input  logic                             start_burst_seq,  // New command, offset back to 0
    input  logic [dma_pkg::AXI_DATA_W-1:0]   rdata,
    input  logic                             rvalid,
    input  logic                             rlast,
    output logic                             rready,
    output logic                             beat_last,
    output dma_pkg::word_addr_t              mem_waddr,
    output logic [dma_pkg::MEM_DATA_W-1:0]   mem_wdata,
    output logic                             mem_wen
);
    import dma_pkg::*;

    axi_beat_u  beat;
    logic       half_q;    // 0 low word pending, 1 high word pending
    word_addr_t offset_q;  // Running buffer word offset

    assign beat.raw = rdata;

    // ==============================
    // Word write path
    // ==============================
    // One word per cycle while the slave holds a beat
    assign mem_wen   = data_phase && rvalid;
    assign mem_wdata = beat.word[half_q];  // Low word first
    assign mem_waddr = offset_q;

    // Beat released with the high word
    assign rready    = data_phase && rvalid && half_q;
    assign beat_last = rready && rlast;  // rready already implies rvalid

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half_q   <= 1'b0;
            offset_q <= '0;
        end else if (start_burst_seq) begin
            half_q   <= 1'b0;
            offset_q <= '0;
        end else if (mem_wen) begin
            half_q   <= ~half_q;
            offset_q <= offset_q + word_addr_t'(1);  // Consecutive word offsets
        end
    end

    // A beat is released only in the cycle after its low word went out
    a_rready_after_low : assert property (
        @(posedge clk) disable iff (!rst_n)
        rready |-> (rvalid && $past(mem_wen))
    );

endmodule

// ==== src/dma_read_top.sv ====
`timescale 1ns/1ps

module dma_read_top (
    input  logic                             clk,
    input  logic                             rst_n,

    // ==============================
    // Command and status
    // ==============================
    input  logic                             start,
    input  dma_pkg::addr_t                   src_addr,
    input  dma_pkg::len_t                    length,      // Bytes, multiple of 8
    input  dma_pkg::buffer_id_t              target_buf,
    output logic                             busy,
    output logic                             done,

    // ==============================
    // AXI4 read master
    // ==============================
    output dma_pkg::addr_t                   araddr,
    output logic [7:0]                       arlen,
    output logic [2:0]                       arsize,
    output logic [1:0]                       arburst,
    output logic                             arvalid,
    input  logic                             arready,
    input  logic [dma_pkg::AXI_DATA_W-1:0]   rdata,
    input  logic                             rlast,
    input  logic                             rvalid,
    output logic                             rready,

    // ==============================
    // Buffer write port
    // ==============================
    output dma_pkg::word_addr_t              mem_waddr,
    output logic [dma_pkg::MEM_DATA_W-1:0]   mem_wdata,
    output logic                             mem_wen,     // No back-pressure
    output dma_pkg::buffer_id_t              mem_target
);
    import dma_pkg::*;

    logic beat_last;   // rlast beat accepted
    logic data_phase;  // Sequencer waiting on R beats

    dma_ctrl_if ctrl_if ();

    // Command latch and burst sizing
    dma_xfer_regs dma_xfer_regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl_if.regs),
        .src_addr   (src_addr),
        .length     (length),
        .target_buf (target_buf),
        .mem_target (mem_target)
    );

    // AR issue and status
    dma_read_fsm dma_read_fsm_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl_if.fsm),
        .start      (start),
        .arready    (arready),
        .arvalid    (arvalid),
        .beat_last  (beat_last),
        .data_phase (data_phase),
        .busy       (busy),
        .done       (done)
    );

    // 64-bit beats to 32-bit words
    beat_unpacker beat_unpacker_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .data_phase      (data_phase),
        .start_burst_seq (ctrl_if.load),
        .rdata           (rdata),
        .rvalid          (rvalid),
        .rlast           (rlast),
        .rready          (rready),
        .beat_last       (beat_last),
        .mem_waddr       (mem_waddr),
        .mem_wdata       (mem_wdata),
        .mem_wen         (mem_wen)
    );

    // AR fields straight from the register block
    assign araddr  = ctrl_if.cur_addr;
    assign arlen   = ctrl_if.cur_arlen;
    assign arsize  = AXI_SIZE_8B;     // Full 8-byte beats
    assign arburst = AXI_BURST_INCR;

    // Registers must not move under a pending AR
    a_ar_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        (arvalid && !arready) |=> ($stable(araddr) && $stable(arlen))
    );

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD  = 2;  // 4 ns clock
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset held low for the first cycles
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;  // Released on an edge, like the stimulus
    end

endmodule

// ==== dv/dma_read_tb.sv ====
`timescale 1ns/1ps

module dma_read_tb;
    import dma_pkg::*;

    localparam logic [31:0] SEED        = 32'h0261a674;
    localparam int          RESET_LIMIT = 20;    // Cycles to leave reset
    localparam int          DONE_LIMIT  = 4000;  // Cycles per transfer
    localparam int          RAND_XFERS  = 4;

    logic clk;
    logic rst_n;

    // DUT inputs
    logic                  start      = 1'b0;
    addr_t                 src_addr   = '0;
    len_t                  length     = '0;
    buffer_id_t            target_buf = BUF_ACT_A;
    logic                  arready    = 1'b0;
    logic [AXI_DATA_W-1:0] rdata      = '0;
    logic                  rlast      = 1'b0;
    logic                  rvalid     = 1'b0;

    // DUT outputs
    logic                  busy;
    logic                  done;
    addr_t                 araddr;
    logic [7:0]            arlen;
    logic [2:0]            arsize;
    logic [1:0]            arburst;
    logic                  arvalid;
    logic                  rready;
    word_addr_t            mem_waddr;
    logic [MEM_DATA_W-1:0] mem_wdata;
    logic                  mem_wen;
    buffer_id_t            mem_target;

    // Slave model state
    addr_t     pend_addr_q[$];   // Accepted bursts not yet returned
    int        pend_len_q[$];
    int        beat_cnt    = 0;
    axi_beat_u slave_beat;
    bit        random_mode = 1'b0;
    addr_t     ar_addr_log[$];   // Every AR seen
    int        ar_len_log[$];

    // Checker state
    addr_t       cur_src     = '0;
    buffer_id_t  cur_target  = BUF_ACT_A;
    int          exp_off     = 0;
    int          write_count = 0;
    int          done_count  = 0;
    bit          low_written = 1'b0;
    logic [31:0] exp_word;

    int    mon_errors   = 0;
    int    slave_errors = 0;
    int    stim_errors  = 0;
    int    xfer_count   = 0;
    bit    timed_out    = 1'b0;
    string test_name    = "reset";

    tb_clk_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dma_read_top dma_read_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .src_addr   (src_addr),
        .length     (length),
        .target_buf (target_buf),
        .busy       (busy),
        .done       (done),
        .araddr     (araddr),
        .arlen      (arlen),
        .arsize     (arsize),
        .arburst    (arburst),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rlast      (rlast),
        .rvalid     (rvalid),
        .rready     (rready),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .mem_wen    (mem_wen),
        .mem_target (mem_target)
    );

    // DRAM content of a word-aligned byte address
    function automatic logic [31:0] ref_word(input addr_t addr);
        ref_word = (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]} ^ 32'hA5C3_0F69;
    endfunction

    // ==============================
    // AXI read slave
    // ==============================
    always @(posedge clk) begin
        if (!rst_n) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rlast    <= 1'b0;
            beat_cnt = 0;
        end else begin
            if (arvalid && arready) begin  // AR handshake
                assert (arsize == AXI_SIZE_8B) else begin
                    $display("mismatch %s arsize: expected %0h, actual %0h",
                             test_name, AXI_SIZE_8B, arsize);
                    slave_errors++;
                end
                assert (arburst == AXI_BURST_INCR) else begin
                    $display("mismatch %s arburst: expected %0h, actual %0h",
                             test_name, AXI_BURST_INCR, arburst);
                    slave_errors++;
                end
                ar_addr_log.push_back(araddr);
                ar_len_log.push_back(int'(arlen));
                pend_addr_q.push_back(araddr);
                pend_len_q.push_back(int'(arlen));
            end
            arready <= random_mode ? ($urandom_range(0, 2) == 0) : 1'b1;  // Random AR delay

            if (rvalid && rready) begin
                if (beat_cnt == pend_len_q[0]) begin  // Burst finished
                    pend_addr_q.delete(0);
                    pend_len_q.delete(0);
                    beat_cnt = 0;
                end else begin
                    beat_cnt++;
                end
            end
            // A presented beat stays until taken, gaps only between beats
            if (!(rvalid && !rready)) begin
                if (pend_len_q.size() != 0 && (!random_mode || $urandom_range(0, 3) != 0)) begin
                    slave_beat.word[0] = ref_word(pend_addr_q[0] + addr_t'(8 * beat_cnt));
                    slave_beat.word[1] = ref_word(pend_addr_q[0] + addr_t'(8 * beat_cnt + 4));
                    rdata  <= slave_beat.raw;
                    rvalid <= 1'b1;
                    rlast  <= (beat_cnt == pend_len_q[0]);
                end else begin
                    rvalid <= 1'b0;
                    rlast  <= 1'b0;
                end
            end
        end
    end

    // ==============================
    // Write checker
    // ==============================
    always @(posedge clk) begin
        if (rst_n) begin
            if (mem_wen) begin
                exp_word = ref_word(cur_src + addr_t'(4 * exp_off));
                assert (mem_waddr == word_addr_t'(exp_off)) else begin
                    $display("mismatch %s mem_waddr: expected %0h, actual %0h",
                             test_name, exp_off, mem_waddr);
                    mon_errors++;
                end
                assert (mem_wdata == exp_word) else begin
                    $display("mismatch %s mem_wdata: expected %0h, actual %0h",
                             test_name, exp_word, mem_wdata);
                    mon_errors++;
                end
                assert (mem_target == cur_target) else begin
                    $display("mismatch %s mem_target: expected %0h, actual %0h",
                             test_name, cur_target, mem_target);
                    mon_errors++;
                end
                exp_off++;
                write_count++;
            end
            if (rready) begin
                assert (low_written) else begin
                    $display("%s: rready high before the low word of its beat was written",
                             test_name);
                    mon_errors++;
                end
            end
            if (rvalid && rready) begin
                low_written = 1'b0;  // Next beat starts over
            end else if (mem_wen) begin
                low_written = 1'b1;
            end
            if (start && !busy) begin  // Command taken, offsets restart
                cur_src    = src_addr;
                cur_target = target_buf;
                exp_off    = 0;
            end
            if (done) begin
                done_count++;
            end
        end
    end

    task automatic expect_bit(input string what, input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("mismatch %s %s: expected %b, actual %b", test_name, what, expected, actual);
            stim_errors++;
        end
    endtask

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("mismatch %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            stim_errors++;
        end
    endtask

    // One command, then status, AR and count checks
    task automatic run_transfer(input string name, input addr_t src, input len_t len,
                                input buffer_id_t tgt, input bit busy_start);
        int    ar_base;
        int    wr_base;
        int    done_base;
        int    cycles;
        int    n_bursts;
        int    beats;
        len_t  rem;
        addr_t addr;
        test_name = name;
        ar_base   = ar_addr_log.size();
        wr_base   = write_count;
        done_base = done_count;
        @(posedge clk);
        start      <= 1'b1;
        src_addr   <= src;
        length     <= len;
        target_buf <= tgt;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        expect_bit("busy after start", 1'b1, busy);
        expect_bit("arvalid after start", 1'b1, arvalid);
        if (busy_start) begin
            start      <= 1'b1;  // Must be ignored while busy
            src_addr   <= src ^ 32'h0010_0000;
            target_buf <= buffer_id_t'(~tgt);
            @(posedge clk);
            start <= 1'b0;
        end
        cycles = 0;
        while (!done && cycles < DONE_LIMIT) begin
            expect_bit("busy until done", 1'b1, busy);
            @(posedge clk);
            cycles++;
        end
        if (done) begin
            expect_bit("busy with done", 1'b0, busy);
            @(posedge clk);
            expect_bit("done width", 1'b0, done);
            // Expected bursts from the remaining bytes
            rem      = len;
            addr     = src;
            n_bursts = 0;
            while (rem != 0) begin
                beats = (rem >= len_t'(BURST_MAX * BEAT_BYTES)) ? BURST_MAX
                                                               : int'(rem) / BEAT_BYTES;
                if (ar_base + n_bursts < ar_addr_log.size()) begin
                    compare_value("araddr", addr, ar_addr_log[ar_base + n_bursts]);
                    compare_value("arlen", 32'(beats - 1), 32'(ar_len_log[ar_base + n_bursts]));
                end
                addr = addr + addr_t'(beats * BEAT_BYTES);
                rem  = rem - len_t'(beats * BEAT_BYTES);
                n_bursts++;
            end
            compare_value("AR count", 32'(n_bursts), 32'(ar_addr_log.size() - ar_base));
            compare_value("write count", len / 4, 32'(write_count - wr_base));
            compare_value("done pulses", 32'd1, 32'(done_count - done_base));
            xfer_count++;
        end else begin
            $display("timeout in %s: done never came after %0d cycles", name, DONE_LIMIT);
            stim_errors++;
            timed_out = 1'b1;
        end
    endtask

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        int         cycles;
        int         total;
        addr_t      rnd_src;
        len_t       rnd_len;
        buffer_id_t rnd_tgt;
        void'($urandom(SEED));
        cycles = 0;
        while (!rst_n && cycles < RESET_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!rst_n) begin
            $display("timeout: reset was never released");
            stim_errors++;
            timed_out = 1'b1;
        end
        repeat (2) @(posedge clk);
        test_name = "reset_idle";  // Quiet outputs before any command
        expect_bit("arvalid", 1'b0, arvalid);
        expect_bit("rready", 1'b0, rready);
        expect_bit("mem_wen", 1'b0, mem_wen);
        expect_bit("busy", 1'b0, busy);
        expect_bit("done", 1'b0, done);

        if (!timed_out) run_transfer("single_burst_24", 32'h0000_1000, 24, BUF_ACT_A, 1'b0);
        if (!timed_out) run_transfer("three_bursts_272", 32'h0002_0040, 272, BUF_WEIGHT, 1'b0);

        random_mode = 1'b1;  // rvalid gaps and arready delay
        if (!timed_out) run_transfer("random_272", 32'h0003_1008, 272, BUF_ACT_B, 1'b0);
        for (int i = 0; i < RAND_XFERS; i++) begin
            rnd_src = addr_t'($urandom) & 32'h0FFF_FFF8;
            rnd_len = len_t'($urandom_range(1, 48)) * len_t'(BEAT_BYTES);
            rnd_tgt = buffer_id_t'(2'($urandom_range(0, 3)));
            if (!timed_out) run_transfer("random_len", rnd_src, rnd_len, rnd_tgt, 1'b0);
        end
        random_mode = 1'b0;

        if (!timed_out) run_transfer("start_while_busy", 32'h0004_0100, 200, BUF_OUTPUT, 1'b1);

        repeat (4) @(posedge clk);
        total = mon_errors + slave_errors + stim_errors;
        $display("Summary: %0d transfers, %0d words checked, %0d ARs, %0d errors",
                 xfer_count, write_count, ar_addr_log.size(), total);
        if (total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
src/dma_pkg.sv
src/dma_ctrl_if.sv
src/dma_xfer_regs.sv
src/dma_read_fsm.sv
src/beat_unpacker.sv
src/dma_read_top.sv
dv/tb_clk_gen.sv
dv/dma_read_tb.sv

// ==== Makefile ====
# Verilator flow for the DMA read engine testbench

TOP = dma_read_tb

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -Mdir obj_dir

# Run and keep the log, then look for the pass line
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
